// File: Bender.yml
package:
  name: sdhci_cmd

export_include_dirs:
  - verilog

sources:
  - verilog/sdhci_cmd_pkg.sv
  - verilog/sd_cmd_frame_builder.sv
  - verilog/sd_cmd_fifo.sv
  - verilog/sd_cmd_line_driver.sv
  - verilog/sdhci_cmd_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/sdhci_cmd_chk.sv
      - tb/tb_sdhci_cmd.sv

// File: tb/sdhci_cmd_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent assertions on the command path ports, bound to the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module sdhci_cmd_chk (
  input logic clk_i,
  input logic rst_i,
  input logic req_i,
  input logic ack_i,
  input logic sd_cmd_i,
  input logic sd_cmd_en_i
);

  // ack answers a request that was seen on the edge before
  ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_i) |-> $past(req_i))
    else $error("cmd_ack_o rose while cmd_req_i was low");

  en_low_after_reset: assert property (@(posedge clk_i)
    rst_i |=> !sd_cmd_en_i)
    else $error("sd_cmd_en_o high in the cycle after reset");

  // idle CMD line is pulled high
  line_high_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    !sd_cmd_en_i |-> sd_cmd_i)
    else $error("sd_cmd_o low while sd_cmd_en_o is low");

endmodule

bind sdhci_cmd_top sdhci_cmd_chk cmd_chk (
  .clk_i       (clk_i),
  .rst_i       (software_reset_cmd_q),
  .req_i       (cmd_req_i),
  .ack_i       (cmd_ack_o),
  .sd_cmd_i    (sd_cmd_o),
  .sd_cmd_en_i (sd_cmd_en_o)
);

// File: tb/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock (40 ns) and power-on reset held for 3 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int Period = 40;

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0; // released away from the sampling edge
  end

endmodule

// File: tb/tb_sdhci_cmd.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the SD command path: stimulus, reference frames,
// CMD line monitor and frame comparison
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "sdhci_settings.svh"

module tb_sdhci_cmd;

  localparam int SdPeriod    = 2 ** (`SDHCI_CLK_DIV_LOG + 1); // system clocks per SD clock
  localparam int AckTimeout  = 1000;
  localparam int IdleTimeout = 5000;

  logic clk_i, por_rst, sw_rst, software_reset_cmd_q;
  logic cmd_req_i, cmd_ack_o, cmd_inhibit_o;
  logic sd_clk_o, sd_cmd_o, sd_cmd_en_o;
  sdhci_cmd_pkg::sd_cmd_req_t cmd_i;

  logic [47:0] exp_q[$];  // expected frames, oldest first
  logic [47:0] got_q[$];  // frames collected from the CMD line
  int          error_count = 0;
  int          seed;

  assign software_reset_cmd_q = por_rst | sw_rst;

  tb_clk_gen clk_gen (
    .clk_o (clk_i),
    .rst_o (por_rst)
  );

  sdhci_cmd_top dut_i (
    .clk_i,
    .software_reset_cmd_q,
    .cmd_req_i,
    .cmd_i,
    .cmd_ack_o,
    .cmd_inhibit_o,
    .sd_clk_o,
    .sd_cmd_o,
    .sd_cmd_en_o
  );

  task automatic stop_on_error(input string what);
    error_count++;
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  // 48-bit command token: 0, 1, index, arg, CRC7 over the first 40 bits, 1
  function automatic logic [47:0] ref_frame(input logic [5:0] index, input logic [31:0] arg);
    logic [39:0] head;
    logic [6:0]  c;
    logic        fb;
    head = {2'b01, index, arg};
    c    = 7'd0;
    for (int i = 39; i >= 0; i--) begin
      fb = head[i] ^ c[6];
      c  = {c[5], c[4], c[3], c[2] ^ fb, c[1], c[0], fb}; // x^7 + x^3 + 1
    end
    return {head, c, 1'b1};
  endfunction

  // four-phase handshake for one command, called on a falling edge
  task automatic send_cmd(input sdhci_cmd_pkg::sd_cmd_req_t req, input bit expect_fast);
    int cycles;
    cycles = 0;
    while (cmd_ack_o && cycles < AckTimeout) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (!cmd_ack_o)
      else stop_on_error("timeout: cmd_ack_o of the previous command stayed high");
    cmd_i     = req;
    cmd_req_i = 1'b1;
    cycles    = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!cmd_ack_o && cycles < AckTimeout);
    assert (cmd_ack_o) else stop_on_error("timeout: cmd_ack_o never rose after cmd_req_i");
    if (expect_fast) begin
      assert (cycles == 1)
        else stop_on_error($sformatf("cmd_ack_o rose %0d cycles after cmd_req_i, not 1", cycles));
    end
    // ack has to hold while req is still high
    @(negedge clk_i);
    assert (cmd_ack_o) else stop_on_error("cmd_ack_o fell while cmd_req_i was still high");
    exp_q.push_back(ref_frame(req.index, req.arg));
    cmd_req_i = 1'b0;
    cycles    = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (cmd_ack_o && cycles < AckTimeout);
    assert (!cmd_ack_o)
      else stop_on_error("timeout: cmd_ack_o never fell after cmd_req_i fell");
    assert (cycles == 1)
      else stop_on_error($sformatf("cmd_ack_o fell %0d cycles after cmd_req_i, not 1", cycles));
  endtask

  // inhibit must hold while any expected frame is still outstanding
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while ((exp_q.size() != 0 || cmd_inhibit_o) && cycles < IdleTimeout) begin
      if (exp_q.size() != 0) begin
        assert (cmd_inhibit_o)
          else stop_on_error("cmd_inhibit_o low before the last frame ended");
      end
      @(negedge clk_i);
      cycles++;
    end
    assert (exp_q.size() == 0 && !cmd_inhibit_o)
      else stop_on_error("timeout: frames not all sent or cmd_inhibit_o still high");
  endtask

  // CMD line monitor, sampled on the system clock
  always @(posedge clk_i) begin : line_monitor
    static logic [47:0] shift_word = '0;
    static int          bit_cnt = 0, en_cycles = 0, gap_clks = 0, frames_seen = 0;
    static logic        sd_clk_d = 1'b0, en_d = 1'b0;
    if (software_reset_cmd_q) begin
      bit_cnt     = 0;
      frames_seen = 0;  // a partial frame is dropped
      sd_clk_d    = 1'b0;
      en_d        = 1'b0;
    end else begin
      if (sd_cmd_en_o && !en_d) begin
        assert (frames_seen == 0 || gap_clks >= 8)
          else stop_on_error($sformatf("only %0d idle SD clocks between frames", gap_clks));
        bit_cnt   = 0;
        en_cycles = 0;
      end
      if (sd_cmd_en_o) en_cycles++;
      if (sd_clk_o && !sd_clk_d) begin
        if (sd_cmd_en_o) begin
          shift_word = {shift_word[46:0], sd_cmd_o};
          bit_cnt++;
        end else begin
          gap_clks++;
        end
      end
      if (!sd_cmd_en_o && en_d) begin // burst just ended
        assert (bit_cnt == 48 && en_cycles == 48 * SdPeriod)
          else stop_on_error($sformatf("burst had %0d SD clocks over %0d cycles", bit_cnt,
                                       en_cycles));
        got_q.push_back(shift_word);
        frames_seen++;
        gap_clks = 0;
      end
      sd_clk_d = sd_clk_o;
      en_d     = sd_cmd_en_o;
    end
  end

  always @(negedge clk_i) begin : compare_frames
    logic [47:0] got, exp;
    if (got_q.size() != 0) begin
      got = got_q.pop_front();
      assert (exp_q.size() != 0) else stop_on_error("a frame appeared with none expected");
      exp = exp_q.pop_front();
      assert (got == exp)
        else stop_on_error($sformatf("mismatch sd_cmd_frame: got 0x%012h expected 0x%012h",
                                     got, exp));
    end
  end

  initial begin : stimulus
    sdhci_cmd_pkg::sd_cmd_req_t req;
    int cycles;
    cmd_req_i = 1'b0;
    cmd_i     = '0;
    sw_rst    = 1'b0;
    seed      = 65;
    cycles    = 0;
    @(negedge clk_i);
    while (software_reset_cmd_q && cycles < 20) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (!software_reset_cmd_q) else stop_on_error("timeout: reset was never released");

    // known tokens from the SD spec
    assert (ref_frame(6'd0, 32'h0) == 48'h400000000095)
      else stop_on_error($sformatf("mismatch ref_frame: got 0x%012h expected 0x%012h",
                                   ref_frame(6'd0, 32'h0), 48'h400000000095));
    assert (ref_frame(6'd8, 32'h1AA) == 48'h48000001AA87)
      else stop_on_error($sformatf("mismatch ref_frame: got 0x%012h expected 0x%012h",
                                   ref_frame(6'd8, 32'h1AA), 48'h48000001AA87));
    send_cmd('{index: 6'd0, arg: 32'h0}, 1'b1);
    wait_idle();
    send_cmd('{index: 6'd8, arg: 32'h000001AA}, 1'b1);
    wait_idle();

    for (int n = 0; n < 20; n++) begin
      req.index = 6'($random(seed));
      req.arg   = $random(seed);
      send_cmd(req, 1'b1);
      wait_idle();
    end

    // back to back, more than the FIFO holds
    for (int n = 0; n < `SDHCI_CMD_FIFO_DEPTH + 3; n++) begin
      req.index = 6'($random(seed));
      req.arg   = $random(seed);
      send_cmd(req, 1'b0);
    end
    wait_idle();

    // soft reset in the middle of a frame with one more queued behind it
    send_cmd('{index: 6'd17, arg: 32'hDEADBEEF}, 1'b1);
    send_cmd('{index: 6'd24, arg: 32'h00C0FFEE}, 1'b1);
    cycles = 0;
    while (!sd_cmd_en_o && cycles < AckTimeout) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (sd_cmd_en_o)
      else stop_on_error("timeout: sd_cmd_en_o never rose before the reset");
    repeat (60) @(negedge clk_i);
    sw_rst = 1'b1;
    exp_q.delete();
    got_q.delete();
    repeat (2) @(negedge clk_i);
    sw_rst = 1'b0;
    @(negedge clk_i);
    assert (!sd_cmd_en_o && !cmd_inhibit_o)
      else stop_on_error("sd_cmd_en_o or cmd_inhibit_o still high after the reset");
    for (int n = 0; n < 300; n++) begin
      assert (!sd_cmd_en_o) else stop_on_error("a discarded frame was sent after the reset");
      @(negedge clk_i);
    end
    send_cmd('{index: 6'd55, arg: 32'h12345678}, 1'b1);
    wait_idle();

    if (error_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "errors were found");
    end
  end

endmodule

// File: verilog/sd_cmd_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular queue of SD command frames with valid/ready pop side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "sdhci_settings.svh"

module sd_cmd_fifo (
  input  logic                         clk_i,
  input  logic                         software_reset_cmd_q,

  input  logic                         push_i,
  input  sdhci_cmd_pkg::sd_cmd_frame_u push_frame_i,
  output logic                         full_o,

  output logic                         pop_valid_o,
  input  logic                         pop_ready_i,
  output sdhci_cmd_pkg::sd_cmd_frame_u pop_frame_o
);

  localparam int Depth = `SDHCI_CMD_FIFO_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);
  localparam logic [PtrW-1:0] LastPtr = PtrW'(Depth - 1);

  sdhci_cmd_pkg::sd_cmd_frame_u mem_q [Depth];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push_en, pop_en;

  assign full_o      = (count_q == CntW'(Depth));
  assign pop_valid_o = (count_q != '0);
  assign pop_frame_o = mem_q[rd_ptr_q];

  assign push_en = push_i & ~full_o;        // push on full is dropped
  assign pop_en  = pop_ready_i & pop_valid_o;

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_frame_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: verilog/sd_cmd_frame_builder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command intake with req/ack handshake, frame assembly with CRC7
// and single-cycle push into the command FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module sd_cmd_frame_builder (
  input  logic                         clk_i,
  input  logic                         software_reset_cmd_q,

  input  logic                         cmd_req_i,
  input  sdhci_cmd_pkg::sd_cmd_req_t   cmd_i,
  output logic                         cmd_ack_o,

  input  logic                         full_i,
  output logic                         push_o,
  output sdhci_cmd_pkg::sd_cmd_frame_u push_frame_o,

  output logic                         busy_o
);

  // CRC7 with generator x^7 + x^3 + 1, MSB first, seeded with zero
  function automatic logic [6:0] crc7(input logic [39:0] data);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb  = data[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (fb) begin
        crc = crc ^ 7'h09;
      end
    end
    return crc;
  endfunction

  logic        cmd_ack_q;
  logic        new_req; // req high, not yet acknowledged
  logic [39:0] header;

  assign new_req = cmd_req_i & ~cmd_ack_q;
  assign header  = {1'b0, 1'b1, cmd_i.index, cmd_i.arg};

  // push as soon as there is room, ack follows on the next edge
  assign push_o = new_req & ~full_i;
  assign busy_o = new_req;  // accepted but not in the FIFO yet

  always_comb begin
    push_frame_o.fields.start_bit = 1'b0;
    push_frame_o.fields.trans_bit = 1'b1;
    push_frame_o.fields.index     = cmd_i.index;
    push_frame_o.fields.arg       = cmd_i.arg;
    push_frame_o.fields.crc       = crc7(header);
    push_frame_o.fields.end_bit   = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      cmd_ack_q <= 1'b0;
    end else if (push_o) begin
      cmd_ack_q <= 1'b1;          // frame is in the FIFO now
    end else if (!cmd_req_i) begin
      cmd_ack_q <= 1'b0;          // host released req
    end
  end

  assign cmd_ack_o = cmd_ack_q;

endmodule

// File: verilog/sd_cmd_line_driver.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD clock divider and CMD line serializer with inter-frame gap
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`include "sdhci_settings.svh"

module sd_cmd_line_driver (
  input  logic                         clk_i,
  input  logic                         software_reset_cmd_q,

  input  logic                         pop_valid_i,
  input  sdhci_cmd_pkg::sd_cmd_frame_u pop_frame_i,
  output logic                         pop_ready_o,

  output logic                         sd_clk_o,
  output logic                         sd_cmd_o,
  output logic                         sd_cmd_en_o,
  output logic                         busy_o
);

  localparam int DivW      = (`SDHCI_CLK_DIV_LOG > 0) ? `SDHCI_CLK_DIV_LOG : 1;
  localparam int FrameBits = `SDHCI_FRAME_BITS;
  localparam int BitCntW   = $clog2(FrameBits);
  localparam logic [DivW-1:0]    HalfMax = DivW'((1 << `SDHCI_CLK_DIV_LOG) - 1);
  localparam logic [BitCntW-1:0] LastBit = BitCntW'(FrameBits - 1);
  localparam logic [2:0]         GapLast = 3'd7; // 8 idle SD clocks

  typedef enum logic [1:0] {
    st_idle,
    st_shift,
    st_gap
  } state_e;

  state_e               state_q;
  logic [DivW-1:0]      div_cnt_q;
  logic                 sd_clk_q;
  logic                 tick;      // sd_clk edge on next clock
  logic                 fall_stb;  // sd_clk about to fall
  logic [FrameBits-1:0] shift_q;
  logic [BitCntW-1:0]   bit_cnt_q;
  logic [2:0]           gap_cnt_q;
  logic                 cmd_q, cmd_en_q;

  assign tick        = (state_q != st_idle) && (div_cnt_q == HalfMax);
  assign fall_stb    = tick & sd_clk_q;
  assign pop_ready_o = (state_q == st_idle) & pop_valid_i;

  // divider restarts from the low phase for every frame
  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      div_cnt_q <= '0;
      sd_clk_q  <= 1'b0;
    end else if (state_q == st_idle) begin
      div_cnt_q <= '0;
      sd_clk_q  <= 1'b0;
    end else begin
      div_cnt_q <= tick ? '0 : div_cnt_q + 1'b1;
      if (tick) begin
        sd_clk_q <= ~sd_clk_q;
      end
    end
  end

  // first bit goes out on load, the rest on each falling edge
  always_ff @(posedge clk_i) begin
    if (pop_ready_o) begin
      shift_q <= {pop_frame_i.raw[FrameBits-2:0], 1'b1};
    end else if (state_q == st_shift && fall_stb) begin
      shift_q <= {shift_q[FrameBits-2:0], 1'b1};
    end
  end

  always_ff @(posedge clk_i) begin
    if (software_reset_cmd_q) begin
      state_q   <= st_idle;
      bit_cnt_q <= '0;
      gap_cnt_q <= '0;
      cmd_q     <= 1'b1;   // line idles high
      cmd_en_q  <= 1'b0;
    end else begin
      case (state_q)
        st_idle: if (pop_ready_o) begin
          state_q   <= st_shift;
          bit_cnt_q <= '0;
          cmd_q     <= pop_frame_i.raw[FrameBits-1];
          cmd_en_q  <= 1'b1;
        end
        st_shift: if (fall_stb) begin
          if (bit_cnt_q == LastBit) begin
            state_q   <= st_gap;
            gap_cnt_q <= '0;
            cmd_q     <= 1'b1;
            cmd_en_q  <= 1'b0;
          end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            cmd_q     <= shift_q[FrameBits-1];
          end
        end
        st_gap: if (fall_stb) begin
          gap_cnt_q <= gap_cnt_q + 1'b1;
          if (gap_cnt_q == GapLast) state_q <= st_idle; // sd_clk is low again here
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign sd_clk_o    = sd_clk_q;
  assign sd_cmd_o    = cmd_q;
  assign sd_cmd_en_o = cmd_en_q;
  assign busy_o      = (state_q != st_idle);

endmodule

// File: verilog/sdhci_cmd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types shared by the SD command path: command request, frame fields
// and the frame union seen as fields or as a raw shift word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "sdhci_settings.svh"

package sdhci_cmd_pkg;

  // what software hands over for one command
  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] arg;
  } sd_cmd_req_t;

  // SD command token as it appears on the CMD line, MSB first
  typedef struct packed {
    logic        start_bit; // always 0
    logic        trans_bit; // 1 = host to card
    logic [5:0]  index;
    logic [31:0] arg;
    logic [6:0]  crc;
    logic        end_bit;   // always 1
  } sd_cmd_frame_t;

  // builder fills in fields, line driver shifts raw
  typedef union packed {
    sd_cmd_frame_t                fields;
    logic [`SDHCI_FRAME_BITS-1:0] raw;
  } sd_cmd_frame_u;

endpackage

// File: verilog/sdhci_cmd_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SD host command path: frame builder, command FIFO and line driver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module sdhci_cmd_top (
  input  logic                       clk_i,
  input  logic                       software_reset_cmd_q,

  input  logic                       cmd_req_i,
  input  sdhci_cmd_pkg::sd_cmd_req_t cmd_i,
  output logic                       cmd_ack_o,
  output logic                       cmd_inhibit_o,

  output logic                       sd_clk_o,
  output logic                       sd_cmd_o,
  output logic                       sd_cmd_en_o
);

  logic                         push, full, builder_busy;
  logic                         pop_valid, pop_ready, driver_busy;
  sdhci_cmd_pkg::sd_cmd_frame_u push_frame, pop_frame;

  sd_cmd_frame_builder i_frame_builder (
    .clk_i,
    .software_reset_cmd_q,
    .cmd_req_i,
    .cmd_i,
    .cmd_ack_o,
    .full_i       (full),
    .push_o       (push),
    .push_frame_o (push_frame),
    .busy_o       (builder_busy)
  );

  sd_cmd_fifo i_cmd_fifo (
    .clk_i,
    .software_reset_cmd_q,
    .push_i       (push),
    .push_frame_i (push_frame),
    .full_o       (full),
    .pop_valid_o  (pop_valid),
    .pop_ready_i  (pop_ready),
    .pop_frame_o  (pop_frame)
  );

  sd_cmd_line_driver i_line_driver (
    .clk_i,
    .software_reset_cmd_q,
    .pop_valid_i (pop_valid),
    .pop_frame_i (pop_frame),
    .pop_ready_o (pop_ready),
    .sd_clk_o,
    .sd_cmd_o,
    .sd_cmd_en_o,
    .busy_o      (driver_busy)
  );

  // queued frames count as busy too
  assign cmd_inhibit_o = builder_busy | pop_valid | driver_busy;

endmodule

// File: verilog/sdhci_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build settings of the SD command path: FIFO depth, SD clock divider
// and the command frame length
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SDHCI_SETTINGS_SVH
`define SDHCI_SETTINGS_SVH

// frames the command FIFO can hold
`define SDHCI_CMD_FIFO_DEPTH 4

// log2 of half an SD clock period in system clocks
// 1 -> sd_clk toggles every 2 cycles, one SD clock = 4 system clocks
`define SDHCI_CLK_DIV_LOG 1

`define SDHCI_FRAME_BITS 48 // start + dir + index + arg + crc7 + end

`endif

// File: vlog.f
+incdir+verilog
verilog/sdhci_cmd_pkg.sv
verilog/sd_cmd_frame_builder.sv
verilog/sd_cmd_fifo.sv
verilog/sd_cmd_line_driver.sv
verilog/sdhci_cmd_top.sv
tb/tb_clk_gen.sv
tb/sdhci_cmd_chk.sv
tb/tb_sdhci_cmd.sv
